//--- source/motorPwmPkg.sv
`default_nettype none

package motorPwmPkg;

    // pwm period counter and requested period length
    localparam int PWM_LEN_W = 12;

    // pulse counter, carry-over and per-segment totals
    localparam int POS_W = 16;

    // segment length and position inside a segment
    localparam int SEG_W = 25;

    // commutation cycle
    localparam int STEP_COUNT = 12;
    localparam int STEP_W = 4;
    localparam int PHASE_COUNT = 3;

    // each phase owns an equal run of consecutive steps
    localparam int STEPS_PER_PHASE = STEP_COUNT / PHASE_COUNT;

    // shortest pulse the gate drivers can follow cleanly
    localparam int PWM_MIN_PULSE = 256;

    // held stable by the host while the driver runs
    typedef struct packed {
        logic [PWM_LEN_W-1:0] pwmLenWant;
        logic [POS_W-1:0]     dutyLen;
        logic [SEG_W-1:0]     segLen;
    } pwmConfig_t;

    // last1 marks count == segLen-2, last2 marks the final cycle
    typedef struct packed {
        logic [SEG_W-1:0] count;
        logic             last1;
        logic             last2;
    } segTick_t;

    // cycles requested and cycles driven over one segment
    typedef struct packed {
        logic [POS_W-1:0] wantTotal;
        logic [POS_W-1:0] realTotal;
    } channelStatus_t;

    // bit 0 is phase A, bit 2 is phase C
    typedef logic [PHASE_COUNT-1:0] phaseVec_t;

endpackage

`default_nettype wire

//--- source/segmentTimer.sv
`timescale 1ns/1ps
`default_nettype none

module segmentTimer import motorPwmPkg::*; (
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire logic             run,
    input  wire logic [SEG_W-1:0] segLen,
    output segTick_t              tick
);

    logic [SEG_W-1:0] countNext;
    logic [SEG_W-1:0] lastCount;
    logic [SEG_W-1:0] preLastCount;

    // positions of the two end strobes inside a segment
    assign lastCount    = segLen - 1'b1;
    assign preLastCount = segLen - 2'd2;

    // wrap at the segment end, fall back to zero when stopped
    always_comb begin
        if (!run) begin
            countNext = '0;
        end else if (tick.count == lastCount) begin
            countNext = '0;
        end else begin
            countNext = tick.count + 1'b1;
        end
    end

    // strobes are decoded from the next count so they sit on the same cycle
    // as the count value they mark; segLen is expected to be at least 3
    always_ff @(posedge clk) begin
        if (rst) begin
            tick <= '0;
        end else begin
            tick.count <= countNext;
            tick.last1 <= run && (countNext == preLastCount);
            tick.last2 <= run && (countNext == lastCount);
        end
    end

endmodule

`default_nettype wire

//--- source/stepSequencer.sv
`timescale 1ns/1ps
`default_nettype none

module stepSequencer import motorPwmPkg::*; (
    input  wire logic                         clk,
    input  wire logic                         rst,
    input  wire logic                         enable,
    input  wire segTick_t                     tick,
    input  wire logic [POS_W-1:0]             dutyLen,
    output logic                              run,
    output logic [STEP_W-1:0]                 step,
    output logic [PHASE_COUNT-1:0][POS_W-1:0] plLen
);

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        STOPPING
    } seqState_t;

    seqState_t         state;
    seqState_t         stateNext;
    logic [STEP_W-1:0] stepNext;
    logic [STEP_W-1:0] stepWrapped;

    // next step of the twelve-step cycle
    assign stepWrapped = (step == STEP_W'(STEP_COUNT - 1)) ? '0 : step + 1'b1;

    always_comb begin
        stateNext = state;
        stepNext  = step;
        case (state)
            IDLE: begin
                // a fresh start always begins on phase A
                if (enable) begin
                    stateNext = RUN;
                    stepNext  = '0;
                end
            end
            RUN: begin
                if (tick.last2) begin
                    stepNext = stepWrapped;
                end
                if (!enable) begin
                    stateNext = STOPPING;
                end
            end
            STOPPING: begin
                // let the current segment finish, step is frozen
                if (tick.last2) begin
                    stateNext = IDLE;
                end
            end
            default: begin
                stateNext = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            step  <= '0;
        end else begin
            state <= stateNext;
            step  <= stepNext;
        end
    end

    // keeps the segment timer going through the stopping segment
    assign run = (state != IDLE);

    // phase p is driven during steps p*4 up to p*4+3
    always_comb begin
        for (int p = 0; p < PHASE_COUNT; p++) begin
            if (run && (int'(step) >= p * STEPS_PER_PHASE) &&
                (int'(step) < (p + 1) * STEPS_PER_PHASE)) begin
                plLen[p] = dutyLen;
            end else begin
                plLen[p] = '0;
            end
        end
    end

endmodule

`default_nettype wire

//--- source/pwmChannel.sv
`timescale 1ns/1ps
`default_nettype none

module pwmChannel import motorPwmPkg::*; (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire logic [POS_W-1:0]     plLen,
    input  wire logic [PWM_LEN_W-1:0] pwmLenWant,
    input  wire segTick_t             tick,
    output logic                      pwm,
    output channelStatus_t            status
);

    // period timing
    logic [PWM_LEN_W-1:0] periodCnt;
    logic                 reload;
    logic                 reloadQ;
    logic                 periodStart;

    // pulse generation
    logic [POS_W-1:0] pulseCnt;
    logic [POS_W-1:0] remain;
    logic [POS_W-1:0] sum;
    logic             sumShort;

    // per-segment bookkeeping
    logic [POS_W-1:0] wantTotal;
    logic [POS_W-1:0] realTotal;
    logic [POS_W-1:0] wantNow;
    logic [POS_W-1:0] realNow;

    // segment end near, period expired, or nothing requested
    assign reload = tick.last1 || (periodCnt == PWM_LEN_W'(1)) || (plLen == '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            periodCnt <= pwmLenWant;
            reloadQ   <= 1'b0;
        end else begin
            reloadQ <= reload;
            if (reload) begin
                periodCnt <= pwmLenWant;
            end else begin
                periodCnt <= periodCnt - 1'b1;
            end
        end
    end

    // first counting cycle after a reload
    assign periodStart = reloadQ && !reload;

    // carried-over request merged with this period's request
    assign sum      = remain + plLen;
    assign sumShort = (sum < POS_W'(PWM_MIN_PULSE));

    // a short request is held back until enough has piled up,
    // so the switches never see a pulse under the minimum
    always_ff @(posedge clk) begin
        if (rst) begin
            pulseCnt <= '0;
        end else begin
            if (periodStart && !sumShort) begin
                pulseCnt <= sum;
            end else if (pulseCnt != '0) begin
                pulseCnt <= pulseCnt - 1'b1;
            end
        end
    end

    // leftover request does not cross a segment boundary
    always_ff @(posedge clk) begin
        if (rst) begin
            remain <= '0;
        end else begin
            if (tick.last2) begin
                remain <= '0;
            end else if (periodStart) begin
                remain <= sumShort ? sum : '0;
            end
        end
    end

    assign pwm = (pulseCnt != '0);

    // running totals with the current cycle folded in, so the final
    // cycle of a segment is attributed to that segment
    assign wantNow = periodStart ? wantTotal + plLen : wantTotal;
    assign realNow = pwm ? realTotal + 1'b1 : realTotal;

    always_ff @(posedge clk) begin
        if (rst) begin
            wantTotal <= '0;
            realTotal <= '0;
        end else begin
            if (tick.last2) begin
                wantTotal <= '0;
                realTotal <= '0;
            end else begin
                wantTotal <= wantNow;
                realTotal <= realNow;
            end
        end
    end

    // status holds until the next segment end
    always_ff @(posedge clk) begin
        if (rst) begin
            status <= '0;
        end else begin
            if (tick.last2) begin
                status.wantTotal <= wantNow;
                status.realTotal <= realNow;
            end
        end
    end

endmodule

`default_nettype wire

//--- source/motorPwmTop.sv
`timescale 1ns/1ps
`default_nettype none

module motorPwmTop import motorPwmPkg::*; (
    input  wire logic                         clk,
    input  wire logic                         rst,
    input  wire logic                         enable,
    input  wire pwmConfig_t                   cfg,
    output phaseVec_t                         pwm,
    output logic [STEP_W-1:0]                 step,
    output logic                              running,
    output channelStatus_t [PHASE_COUNT-1:0]  status
);

    segTick_t                          tick;
    logic [PHASE_COUNT-1:0][POS_W-1:0] plLen;

    // segment boundaries shared by the sequencer and all channels
    segmentTimer u_segmentTimer (
        .clk    (clk),
        .rst    (rst),
        .run    (running),
        .segLen (cfg.segLen),
        .tick   (tick)
    );

    // running doubles as the timer's run level
    stepSequencer u_stepSequencer (
        .clk     (clk),
        .rst     (rst),
        .enable  (enable),
        .tick    (tick),
        .dutyLen (cfg.dutyLen),
        .run     (running),
        .step    (step),
        .plLen   (plLen)
    );

    // one channel per motor phase
    for (genvar i = 0; i < PHASE_COUNT; i++) begin : genChannel
        pwmChannel u_pwmChannel (
            .clk        (clk),
            .rst        (rst),
            .plLen      (plLen[i]),
            .pwmLenWant (cfg.pwmLenWant),
            .tick       (tick),
            .pwm        (pwm[i]),
            .status     (status[i])
        );
    end

endmodule

`default_nettype wire

//--- dv/tbMotorPwm.sv
`timescale 1ns/1ps
`default_nettype none

module tbMotorPwm import motorPwmPkg::*; ();

    localparam int ROW_COUNT = 8;
    localparam int TIMEOUT_SLACK = 16;

    // expPulse is the exact pulse length or 0 where only the minimum pulse applies
    typedef struct packed {
        int pwmLenWant;
        int dutyLen;
        int segLen;
        int segCount;
        int expPulse;
    } rowSpec_t;

    logic                             clk;
    logic                             rst;
    logic                             enable;
    pwmConfig_t                       cfg;
    phaseVec_t                        pwm;
    logic [STEP_W-1:0]                step;
    logic                             running;
    channelStatus_t [PHASE_COUNT-1:0] status;

    rowSpec_t    rows [ROW_COUNT];
    logic [15:0] lfsrState = 16'd33;
    int statusErrors = 0;
    int stepErrors = 0;
    int pwmErrors = 0;
    int countErrors = 0;
    int otherErrors = 0;
    bit aborted = 1'b0;
    bit monitorOn = 1'b0;

    // parameters of the row being applied
    int curDuty = 0;
    int curSegLen = 0;
    int curExact = 0;
    int runOnLimit = 0;

    // monitor state
    int highLen [PHASE_COUNT];
    int pulseCount [PHASE_COUNT];
    int minPulse [PHASE_COUNT];
    int maxPulse [PHASE_COUNT];
    int outsideLen [PHASE_COUNT];
    int windowSegs [PHASE_COUNT];
    int wantSum [PHASE_COUNT];
    int realSum [PHASE_COUNT];
    bit windowSkip [PHASE_COUNT];
    int segCycles = 0;
    int rowSegs = 0;
    logic prevRunning = 1'b0;
    logic [STEP_W-1:0] prevStep = '0;

    motorPwmTop u_motorPwmTop (
        .clk     (clk),
        .rst     (rst),
        .enable  (enable),
        .cfg     (cfg),
        .pwm     (pwm),
        .step    (step),
        .running (running),
        .status  (status)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    // 16-bit Fibonacci LFSR, taps 16 14 13 11, one step per bit taken
    function automatic int randomBits(input int count);
        int value;
        value = 0;
        for (int i = 0; i < count; i++) begin
            value = (value << 1) | int'(lfsrState[15]);
            lfsrState = {lfsrState[14:0],
                         lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10]};
        end
        return value;
    endfunction

    function automatic logic [STEP_W-1:0] nextStep(input logic [STEP_W-1:0] s);
        return STEP_W'((int'(s) + 1) % STEP_COUNT);
    endfunction

    task automatic checkStatus(input string name, input channelStatus_t got,
                               input channelStatus_t exp);
        if (got !== exp) begin
            statusErrors++;
            $display("[FAIL] %s: got want %0h real %0h, expected want %0h real %0h",
                     name, got.wantTotal, got.realTotal, exp.wantTotal, exp.realTotal);
        end
    endtask

    task automatic checkStep(input string name, input logic [STEP_W-1:0] got,
                             input logic [STEP_W-1:0] exp);
        if (got !== exp) begin
            stepErrors++;
            $display("[FAIL] %s: got %0h, expected %0h", name, got, exp);
        end
    endtask

    task automatic checkPwm(input string name, input phaseVec_t got, input phaseVec_t exp);
        if (got !== exp) begin
            pwmErrors++;
            $display("[FAIL] %s: got %0h, expected %0h", name, got, exp);
        end
    endtask

    task automatic checkCount(input string name, input int got, input int exp);
        if (got != exp) begin
            countErrors++;
            $display("[FAIL] %s: got %0h, expected %0h", name, got, exp);
        end
    endtask

    task automatic checkRange(input string name, input int got, input int lo, input int hi);
        if (got < lo || got > hi) begin
            countErrors++;
            $display("[FAIL] %s: got %0h, expected %0h to %0h", name, got, lo, hi);
        end
    endtask

    task automatic fillRows();
        int randDuty;
        // 9 random bits keep the pulse inside 256..767, below the 800 cycle period
        randDuty = PWM_MIN_PULSE + randomBits(9);
        rows[0] = '{600, 300, 1800, 13, 300};
        rows[1] = '{1000, 700, 3000, 13, 700};
        rows[2] = '{600, 100, 1800, 13, 0};
        rows[3] = '{400, 0, 1200, 13, 0};
        rows[4] = '{800, randDuty, 2400, 13, randDuty};
        rows[5] = '{500, 256, 1500, 13, 256};
        rows[6] = '{300, 70, 900, 13, 0};
        rows[7] = '{300, 298, 1200, 13, 298};
    endtask

    task automatic clearMonitors();
        for (int p = 0; p < PHASE_COUNT; p++) begin
            highLen[p] = 0;
            pulseCount[p] = 0;
            minPulse[p] = 1 << 30;
            maxPulse[p] = 0;
            outsideLen[p] = runOnLimit + 1;
            windowSegs[p] = 0;
            wantSum[p] = 0;
            realSum[p] = 0;
            windowSkip[p] = 1'b0;
        end
        rowSegs = 0;
    endtask

    // status of the segment that ran with step s, latched at its end
    task automatic checkSegment(input logic [STEP_W-1:0] s);
        int owner;
        int want;
        int realCycles;
        string name;
        owner = int'(s) / STEPS_PER_PHASE;
        for (int p = 0; p < PHASE_COUNT; p++) begin
            want = int'(status[p].wantTotal);
            realCycles = int'(status[p].realTotal);
            name = $sformatf("status[%0d]", p);
            if (rowSegs == 0 && (curDuty == 0 || p != owner)) begin
                // the previous row's last pulse ran on into this first segment
                checkCount({name, ".wantTotal"}, want, 0);
            end else if (curDuty == 0) begin
                checkStatus(name, status[p], '0);
            end else if (p == owner) begin
                if (windowSegs[p] == 0) begin
                    windowSkip[p] = (rowSegs == 0);
                end
                windowSegs[p]++;
                wantSum[p] += want;
                realSum[p] += realCycles;
                checkCount({name, ".wantTotal mod dutyLen"}, want % curDuty, 0);
                checkRange({name, ".wantTotal"}, want, 1, 65535);
            end else if (windowSegs[p] == STEPS_PER_PHASE) begin
                realSum[p] += realCycles;
                checkCount({name, ".wantTotal"}, want, 0);
                if (curExact != 0) begin
                    checkCount({name, ".realTotal after window"}, realCycles, curExact);
                end
                if (!windowSkip[p]) begin
                    checkRange({name, " window realTotal sum"}, realSum[p], 0, wantSum[p]);
                    if (curExact != 0) begin
                        checkCount({name, " window realTotal sum"}, realSum[p], wantSum[p]);
                    end
                end
                windowSegs[p] = 0;
                wantSum[p] = 0;
                realSum[p] = 0;
            end else begin
                checkStatus(name, status[p], '0);
            end
        end
    endtask

    task automatic watchSteps();
        if (running && !prevRunning) begin
            checkStep("step at start", step, '0);
            segCycles = 1;
        end else if (running) begin
            if (step != prevStep) begin
                checkCount("segment length", segCycles, curSegLen);
                checkStep("step", step, nextStep(prevStep));
                checkSegment(prevStep);
                rowSegs++;
                segCycles = 1;
            end else begin
                segCycles++;
            end
        end
        prevRunning = running;
        prevStep = step;
    endtask

    // all outputs are sampled on the falling edge
    always @(negedge clk) begin
        phaseVec_t allowed;
        if (monitorOn) begin
            for (int p = 0; p < PHASE_COUNT; p++) begin
                if (running && (int'(step) / STEPS_PER_PHASE == p)) begin
                    outsideLen[p] = 0;
                end else if (outsideLen[p] <= runOnLimit) begin
                    outsideLen[p]++;
                end
                allowed[p] = (curDuty != 0) && (outsideLen[p] <= runOnLimit);
                if (pwm[p]) begin
                    highLen[p]++;
                end else if (highLen[p] != 0) begin
                    pulseCount[p]++;
                    if (highLen[p] < minPulse[p]) begin
                        minPulse[p] = highLen[p];
                    end
                    if (highLen[p] > maxPulse[p]) begin
                        maxPulse[p] = highLen[p];
                    end
                    highLen[p] = 0;
                end
            end
            checkPwm("pwm outside its window", pwm & ~allowed, '0);
            watchSteps();
        end
    end

    task automatic checkPulses();
        for (int p = 0; p < PHASE_COUNT; p++) begin
            if (curDuty == 0) begin
                checkCount($sformatf("pulses on pwm[%0d]", p), pulseCount[p], 0);
            end else if (curExact != 0) begin
                checkRange($sformatf("pulses on pwm[%0d]", p), pulseCount[p], 1, 1 << 30);
                checkCount($sformatf("shortest pulse on pwm[%0d]", p), minPulse[p], curExact);
                checkCount($sformatf("longest pulse on pwm[%0d]", p), maxPulse[p], curExact);
            end else if (pulseCount[p] != 0) begin
                checkRange($sformatf("shortest pulse on pwm[%0d]", p), minPulse[p],
                           PWM_MIN_PULSE, 1 << 30);
            end
        end
    endtask

    task automatic runRow(input rowSpec_t row, input int idx);
        int cycles;
        int changes;
        logic [STEP_W-1:0] lastStep;
        @(posedge clk);
        cfg.pwmLenWant <= PWM_LEN_W'(row.pwmLenWant);
        cfg.dutyLen <= POS_W'(row.dutyLen);
        cfg.segLen <= SEG_W'(row.segLen);
        curDuty = row.dutyLen;
        curSegLen = row.segLen;
        curExact = row.expPulse;
        runOnLimit = row.dutyLen + PWM_MIN_PULSE;
        clearMonitors();
        enable <= 1'b1;
        cycles = 0;
        while (!running && cycles < TIMEOUT_SLACK) begin
            @(negedge clk);
            cycles++;
        end
        if (!running) begin
            $display("row %0d: running never rose after enable went high", idx);
            otherErrors++;
            aborted = 1'b1;
            return;
        end
        changes = 0;
        cycles = 0;
        lastStep = step;
        while (changes < row.segCount && cycles < row.segLen * (row.segCount + 1)) begin
            @(negedge clk);
            cycles++;
            if (step != lastStep) begin
                changes++;
                lastStep = step;
            end
        end
        if (changes < row.segCount) begin
            $display("row %0d: only %0d of %0d segment ends seen", idx, changes, row.segCount);
            otherErrors++;
            aborted = 1'b1;
            return;
        end
        @(posedge clk);
        enable <= 1'b0;
        cycles = 0;
        while (running && cycles < row.segLen + TIMEOUT_SLACK) begin
            @(negedge clk);
            cycles++;
        end
        if (running) begin
            $display("row %0d: running stayed high after enable went low", idx);
            otherErrors++;
            aborted = 1'b1;
            return;
        end
        // enable fell after the first cycle of a segment, so the rest of it still runs
        checkCount("cycles from enable low to running low", cycles, row.segLen);
        cycles = 0;
        while ((pwm != '0 || cycles < 4) && cycles < runOnLimit + TIMEOUT_SLACK) begin
            @(negedge clk);
            cycles++;
            checkStep("step after stop", step, lastStep);
        end
        if (pwm != '0) begin
            $display("row %0d: pwm stayed high after the driver stopped", idx);
            otherErrors++;
            aborted = 1'b1;
            return;
        end
        @(posedge clk);
        checkPulses();
    endtask

    initial begin
        int total;
        rst = 1'b1;
        enable = 1'b0;
        cfg = '0;
        fillRows();
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        // idle outputs with enable low
        repeat (8) begin
            @(negedge clk);
            checkPwm("pwm", pwm, '0);
            checkStep("step", step, '0);
            checkCount("running", running ? 1 : 0, 0);
            for (int p = 0; p < PHASE_COUNT; p++) begin
                checkStatus($sformatf("status[%0d]", p), status[p], '0);
            end
        end
        @(posedge clk);
        monitorOn = 1'b1;
        for (int r = 0; r < ROW_COUNT; r++) begin
            if (aborted) begin
                break;
            end
            runRow(rows[r], r);
        end
        total = statusErrors + stepErrors + pwmErrors + countErrors + otherErrors;
        $display("errors: status %0d, step %0d, pwm %0d, count %0d, other %0d",
                 statusErrors, stepErrors, pwmErrors, countErrors, otherErrors);
        if (total == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
source/motorPwmPkg.sv
source/segmentTimer.sv
source/stepSequencer.sv
source/pwmChannel.sv
source/motorPwmTop.sv
dv/tbMotorPwm.sv

//--- Makefile
# Verilator build and run of the motor PWM testbench

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove the build folder and the log"

test:
	verilator --binary --timing -Wno-fatal -f flist.f --top-module tbMotorPwm -Mdir obj_dir
	./obj_dir/VtbMotorPwm | tee sim.log
	grep -q "Simulation completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log
